// ==== sources.f ====
phase_pkg.sv
mmcm_pkg.sv
mmcm_fine_ps.sv
mmcm_phase_cntr.sv
mmcm_phase_top.sv
tb_mmcm_phase.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the phase controller testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f sources.f \
    --top-module tb_mmcm_phase \
    -o tb_sim \
    && ./obj_dir/tb_sim 2>&1 | tee sim.log \
    && grep -qx "test passed" sim.log \
    && echo "simulation ok" \
    || { echo "simulation did not pass, see sim.log"; exit 1; }

// ==== tb_mmcm_phase.sv ====
`timescale 1ns/1ns

module tb_mmcm_phase;

    // expected outcome of one absolute write
    typedef struct packed {
        phase_pkg::phase_t                  fin;   // phase after the shift
        logic signed [phase_pkg::phase_w:0] delta; // signed tap distance
        logic signed [1:0]                  dir;   // +1 up, -1 down, 0 none
    } ref_t;

    logic                psclk;
    logic                rst;
    logic                pwrdwn;
    phase_pkg::ps_req_t  ps_req;
    phase_pkg::ps_stat_t ps_stat;
    logic                locked;

    int                err_cnt;   // wrong values
    int                to_cnt;    // timeouts
    int                chg_cnt;   // dout changes seen by the monitor
    int                exp_cnt;   // steps the reference expects
    ref_t              exp_ref;   // reference for the running write
    logic signed [1:0] exp_dir;   // direction every change must have
    string             cur_test;  // name used by the monitor
    phase_pkg::phase_t prev_dout; // monitor history
    phase_pkg::phase_t hold_ph;   // phase kept across power-down

    logic signed [phase_pkg::phase_w:0] step_d; // monitor step size

    phase_pkg::phase_t dir_vals [5] = '{8'sh05, 8'shfd, 8'sh7f, 8'sh80, 8'sh00};

    mmcm_phase_top u_dut (
        .psclk   (psclk),
        .rst     (rst),
        .pwrdwn  (pwrdwn),
        .ps_req  (ps_req),
        .ps_stat (ps_stat),
        .locked  (locked)
    );

    always #5 psclk = ~psclk; // 10 ns period

    // absolute write, target is the written value, distance in 9 bits
    function automatic ref_t ref_phase(input phase_pkg::phase_t old_ph,
                                       input phase_pkg::phase_t wr);
        ref_t r;
        int   d;
        d       = int'(wr) - int'(old_ph); // -255 .. +255 taps
        r.fin   = wr;
        r.delta = 9'(d);
        if (d > 0) begin
            r.dir = 2'sb01; // walk up
        end else if (d < 0) begin
            r.dir = 2'sb11; // walk down
        end else begin
            r.dir = 2'sb00; // already there
        end
        return r;
    endfunction

    task automatic check_phase(input string name, input phase_pkg::phase_t exp_v,
                               input phase_pkg::phase_t act_v);
        if (act_v !== exp_v) begin
            $display("FAIL %s expected %0d actual %0d", name, exp_v, act_v);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("FAIL %s expected %b actual %b", name, exp_v, act_v);
            err_cnt++;
        end
    endtask

    task automatic check_count(input string name, input int exp_v, input int act_v);
        if (act_v != exp_v) begin
            $display("FAIL %s expected %0d steps actual %0d steps", name, exp_v, act_v);
            err_cnt++;
        end
    endtask

    task automatic wait_ready(input string name, input int limit);
        int n;
        n = 0;
        while (ps_stat.ready !== 1'b1 && n < limit) begin
            @(negedge psclk); // sample away from the drive edge
            n++;
        end
        if (ps_stat.ready !== 1'b1) begin
            $display("%s: ready did not come back within %0d cycles", name, limit);
            to_cnt++;
        end
    endtask

    task automatic wait_locked(input string name, input int limit);
        int n;
        n = 0;
        while (locked !== 1'b1 && n < limit) begin
            @(negedge psclk);
            n++;
        end
        if (locked !== 1'b1) begin
            $display("%s: locked did not rise within %0d cycles", name, limit);
            to_cnt++;
        end
    endtask

    // one-cycle strobe, called 1 ns after an edge
    task automatic pulse_we(input phase_pkg::phase_t val);
        ps_req.we  = 1'b1;
        ps_req.din = val;
        @(posedge psclk);
        #1;
        ps_req.we  = 1'b0;
    endtask

    task automatic start_write(input string name, input phase_pkg::phase_t val);
        @(posedge psclk);
        #1;
        exp_ref  = ref_phase(ps_stat.dout, val);
        exp_dir  = exp_ref.dir;
        exp_cnt  = (exp_ref.delta < 9'sd0) ? -int'(exp_ref.delta) : int'(exp_ref.delta);
        chg_cnt  = 0;
        cur_test = name;
        pulse_we(val);
    endtask

    task automatic finish_write(input string name);
        wait_ready(name, (exp_cnt + 2) * (mmcm_pkg::psdone_lat + 1) + 8); // per-step budget
        check_phase(name, exp_ref.fin, ps_stat.dout);
        check_count(name, exp_cnt, chg_cnt);
    endtask

    task automatic write_phase(input string name, input phase_pkg::phase_t val);
        start_write(name, val);
        finish_write(name);
    endtask

    // every dout change must be one tap in the expected direction
    always @(negedge psclk) begin
        if (rst) begin
            prev_dout = ps_stat.dout;
        end else if (ps_stat.dout !== prev_dout) begin
            step_d = {ps_stat.dout[phase_pkg::phase_w-1], ps_stat.dout}
                   - {prev_dout[phase_pkg::phase_w-1], prev_dout}; // 9-bit, no wrap
            if (step_d != 9'(exp_dir)) begin
                $display("FAIL %s step expected %0d actual %0d", cur_test, exp_dir, step_d);
                err_cnt++;
            end
            chg_cnt   = chg_cnt + 1;
            prev_dout = ps_stat.dout;
        end
    end

    initial begin
        void'($urandom(32'hc09d_63b8)); // single seed for the run
        psclk    = 1'b0;
        rst      = 1'b1;
        pwrdwn   = 1'b0;
        ps_req   = '0;
        err_cnt  = 0;
        to_cnt   = 0;
        chg_cnt  = 0;
        exp_cnt  = 0;
        exp_dir  = 2'sb00;
        exp_ref  = '0;
        hold_ph  = '0;
        cur_test = "reset";

        repeat (10) @(posedge psclk);
        #1;
        check_flag("reset_ready", 1'b0, ps_stat.ready);
        check_flag("reset_locked", 1'b0, locked);
        check_phase("reset_dout", 8'sh00, ps_stat.dout);
        rst = 1'b0;
        wait_locked("lock", mmcm_pkg::lock_cycles + 8);
        check_flag("lock_ready", 1'b1, ps_stat.ready); // ready follows lock

        foreach (dir_vals[k]) begin
            write_phase($sformatf("directed_%0d", dir_vals[k]), dir_vals[k]); // incl +127 -> -128
        end

        for (int i = 0; i < 30; i++) begin
            write_phase($sformatf("random_%0d", i), phase_pkg::phase_t'($urandom));
        end

        write_phase("busy_setup", 8'shec);
        start_write("busy_ignore", 8'sh40); // 84 taps up
        repeat (30) @(posedge psclk);
        #1;
        pulse_we(8'shc0); // mid-shift, must be dropped
        finish_write("busy_ignore");

        write_phase("zero_distance", ps_stat.dout); // no steps, short wait

        cur_test = "pwrdwn";
        exp_dir  = 2'sb00; // any change is an error
        hold_ph  = ps_stat.dout;
        @(posedge psclk);
        #1;
        pwrdwn = 1'b1;
        repeat (2) @(posedge psclk);
        #1;
        check_flag("pwrdwn_locked", 1'b0, locked);
        check_flag("pwrdwn_ready", 1'b0, ps_stat.ready);
        pulse_we(hold_ph + 8'sd9); // ignored while down
        repeat (5) @(posedge psclk);
        #1;
        check_phase("pwrdwn_hold", hold_ph, ps_stat.dout);
        pwrdwn = 1'b0;
        wait_locked("pwrdwn_relock", mmcm_pkg::lock_cycles + 8);
        check_phase("relock_hold", hold_ph, ps_stat.dout);
        check_flag("relock_ready", 1'b1, ps_stat.ready);
        write_phase("after_pwrdwn", 8'shd3);

        $display("errors: %0d wrong values, %0d timeouts", err_cnt, to_cnt);
        if (err_cnt == 0 && to_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== mmcm_phase_top.sv ====
`timescale 1ns/1ns

// phase controller with its clock manager model
// no logic here, the counter drives the model's phase shift port
module mmcm_phase_top (
    input  logic                psclk,  // phase shift clock
    input  logic                rst,    // sync reset, high
    input  logic                pwrdwn, // clock manager power-down
    input  phase_pkg::ps_req_t  ps_req, // client write
    output phase_pkg::ps_stat_t ps_stat, // client status
    output logic                locked  // clock manager lock
);

    phase_pkg::ps_step_t ps_step; // counter -> clock manager
    logic                psdone;  // clock manager -> counter

    // absolute phase counter
    mmcm_phase_cntr u_cntr (
        .psclk   (psclk),
        .rst     (rst),
        .ps_req  (ps_req),
        .psdone  (psdone),
        .locked  (locked),  // gates ready
        .ps_stat (ps_stat),
        .ps_step (ps_step)
    );

    // clock manager, fine phase shift and lock only
    mmcm_fine_ps u_mmcm (
        .psclk   (psclk),
        .rst     (rst),
        .pwrdwn  (pwrdwn),
        .ps_step (ps_step),
        .psdone  (psdone),  // back to the counter
        .locked  (locked)   // to the counter and out
    );

endmodule

// ==== mmcm_phase_cntr.sv ====
`timescale 1ns/1ns

// absolute phase controller
// takes a signed target and walks the fine shifter one tap per done pulse
module mmcm_phase_cntr (
    input  logic                psclk,   // phase shift clock
    input  logic                rst,     // sync reset, high
    input  phase_pkg::ps_req_t  ps_req,  // write strobe and target
    input  logic                psdone,  // done pulse from clock manager
    input  logic                locked,  // clock manager locked
    output phase_pkg::ps_stat_t ps_stat, // ready and current phase
    output phase_pkg::ps_step_t ps_step  // step request to clock manager
);

    phase_pkg::phase_t target; // requested phase
    phase_pkg::phase_t dout_r; // phase applied so far

    logic busy;   // shift sequence running
    logic start0; // first stage after an accepted write
    logic start;  // evaluate difference and maybe step
    logic accept; // write taken this cycle
    logic step_wait; // step issued, done not yet seen

    // one bit wider than the phase so +127 -> -128 does not wrap
    logic signed [phase_pkg::phase_w:0] diff;

    assign diff = {target[phase_pkg::phase_w-1], target}
                - {dout_r[phase_pkg::phase_w-1], dout_r}; // sign extended

    assign ps_stat.ready = !busy && locked && !start0 && !start; // idle and locked
    assign ps_stat.dout  = dout_r;

    assign accept = ps_req.we && ps_stat.ready; // strobe outside ready is dropped

    assign ps_step.en     = start && (diff != '0);         // step only when off target
    assign ps_step.incdec = !diff[phase_pkg::phase_w];     // sign picks direction

    // target register
    always_ff @(posedge psclk) begin
        if (rst) begin
            target <= '0;
        end else if (accept) begin
            target <= ps_req.din; // latched at the write edge
        end
    end

    // current phase, mirrors each step sent out
    always_ff @(posedge psclk) begin
        if (rst) begin
            dout_r <= '0;
        end else if (ps_step.en) begin
            if (ps_step.incdec) begin
                dout_r <= dout_r + phase_pkg::phase_t'(1); // towards larger target
            end else begin
                dout_r <= dout_r - phase_pkg::phase_t'(1); // towards smaller target
            end
        end
    end

    // start chain
    // write -> start0 -> start, then each done pulse -> start
    always_ff @(posedge psclk) begin
        if (rst) begin
            start0 <= 1'b0;
            start  <= 1'b0;
        end else begin
            start0 <= accept;
            start  <= start0 || psdone; // one cycle after done
        end
    end

    // busy flag
    // set by a step, cleared by a start that finds no difference
    always_ff @(posedge psclk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= (diff != '0);
        end
    end

    // outstanding step tracker, closes on the done pulse
    always_ff @(posedge psclk) begin
        if (rst) begin
            step_wait <= 1'b0;
        end else if (ps_step.en) begin
            step_wait <= 1'b1; // waiting for the clock manager
        end else if (psdone) begin
            step_wait <= 1'b0;
        end
    end

    // each step brings dout one tap closer to the held target
    a_dout_step: assert property (
        @(posedge psclk) disable iff (rst)
        ps_step.en |=>
            (($past(diff) > 0) ? ($past(diff) - diff) : (diff - $past(diff))) == 9'sd1
    ) else $error("dout did not move one tap towards the target after a step");

    // next step only after the done pulse of the previous one
    a_wait_done: assert property (
        @(posedge psclk) disable iff (rst)
        ps_step.en |-> !step_wait
    ) else $error("step issued before previous done pulse");

endmodule

// ==== mmcm_fine_ps.sv ====
`timescale 1ns/1ns

// cycle-level model of the clock manager phase shift port
// only PSEN/PSINCDEC/PSDONE and LOCKED are modelled, no clocks
module mmcm_fine_ps (
    input  logic                psclk,   // phase shift clock
    input  logic                rst,     // sync reset, high
    input  logic                pwrdwn,  // power-down request
    input  phase_pkg::ps_step_t ps_step, // step request from the counter
    output logic                psdone,  // one-cycle done pulse
    output logic                locked   // lock indication
);

    // done pulse delay line, bit 0 loads the request
    logic [mmcm_pkg::psdone_lat-1:0] done_pipe;

    // tap position the device has actually applied
    phase_pkg::phase_t tap_pos;

    // lock timer, runs from 1 up to lock_cycles and stops there
    mmcm_pkg::lock_cnt_t lock_cnt;

    // any condition that throws the device out of lock
    logic halt;

    assign halt = rst | pwrdwn; // both restart the lock sequence

    // done pulse pipeline
    always_ff @(posedge psclk) begin
        if (halt) begin
            done_pipe <= '0; // pending steps are lost
        end else begin
            done_pipe <= {done_pipe[mmcm_pkg::psdone_lat-2:0], ps_step.en}; // shift in request
        end
    end

    assign psdone = done_pipe[mmcm_pkg::psdone_lat-1]; // psdone_lat cycles after en

    // internal tap position
    // follows every request, power-down keeps it
    always_ff @(posedge psclk) begin
        if (rst) begin
            tap_pos <= '0; // back to static phase
        end else if (ps_step.en) begin
            if (ps_step.incdec) begin
                tap_pos <= tap_pos + phase_pkg::phase_t'(1); // one tap later
            end else begin
                tap_pos <= tap_pos - phase_pkg::phase_t'(1); // one tap earlier
            end
        end
    end

    // lock timer
    // restarts at 1 so that locked rises exactly lock_cycles after release
    always_ff @(posedge psclk) begin
        if (halt) begin
            lock_cnt <= mmcm_pkg::lock_cnt_t'(1); // first cycle after release
        end else if (!locked) begin
            lock_cnt <= lock_cnt + mmcm_pkg::lock_cnt_t'(1); // count up to lock
        end
    end

    assign locked = (lock_cnt == mmcm_pkg::lock_cnt_t'(mmcm_pkg::lock_cycles)); // held at top

    // one step at a time, the port is not pipelined for requests
    a_single_step: assert property (
        @(posedge psclk) disable iff (rst)
        ps_step.en |-> (done_pipe == '0)
    ) else $error("step request while a previous step is still in flight");

    // stepping an unlocked device has no defined result
    a_step_locked: assert property (
        @(posedge psclk) disable iff (rst)
        ps_step.en |-> locked
    ) else $error("step request while not locked");

    // tap range ends at +127 and -128, a step past either end would wrap
    a_tap_range: assert property (
        @(posedge psclk) disable iff (rst)
        ps_step.en |-> (ps_step.incdec ? (tap_pos != phase_pkg::phase_t'(127))
                                       : (tap_pos != phase_pkg::phase_t'(-128)))
    ) else $error("step request beyond the end of the tap range");

endmodule

// ==== mmcm_pkg.sv ====
package mmcm_pkg;

    // fine phase shift port of the clock manager
    // a done pulse answers every step request after a fixed delay
    localparam int psdone_lat = 12; // psclk cycles from en to done

    // lock behaviour
    // lock comes back a fixed time after rst or power-down is released
    localparam int lock_cycles = 64; // psclk cycles to lock

    // counter width, must hold lock_cycles itself
    localparam int lock_cnt_w = $clog2(lock_cycles + 1);

    typedef logic [lock_cnt_w-1:0] lock_cnt_t; // lock timer

endpackage

// ==== phase_pkg.sv ====
package phase_pkg;

    // phase word, signed taps of the fine phase shifter
    localparam int phase_w = 8; // enough for +-127 taps

    typedef logic signed [phase_w-1:0] phase_t; // two's complement tap count

    // client write port
    typedef struct packed {
        logic   we;  // one-cycle write strobe
        phase_t din; // absolute target phase
    } ps_req_t;

    // client status port
    typedef struct packed {
        logic   ready; // next write will be taken
        phase_t dout;  // phase applied so far
    } ps_stat_t;

    // one tap step towards the clock manager
    typedef struct packed {
        logic en;     // single-cycle request
        logic incdec; // 1 = one tap later, 0 = one tap earlier
    } ps_step_t;

endpackage
